//--- logic/bpred_cfg.svh
`ifndef BPRED_CFG_SVH
`define BPRED_CFG_SVH

// datapath word width, instructions and addresses alike
`define BPRED_XLEN 32

// branch history table
// one 2-bit counter per entry
`define BPRED_BHT_ENTRIES 128
// index taken from pc[8:2]
`define BPRED_BHT_IDX_W 7

// branch target buffer, direct mapped
`define BPRED_BTB_ENTRIES 8
// index taken from pc[4:2]
`define BPRED_BTB_IDX_W 3
// tag is pc[31:5]
`define BPRED_BTB_TAG_W 27

// first fetch address out of reset
`define BPRED_RESET_PC 32'h0000_0060

`endif

//--- logic/bpred_pkg.sv
`include "bpred_cfg.svh"

package bpred_pkg;

    // one instruction word or one byte address
    typedef logic [`BPRED_XLEN-1:0] word_t;

    // two-bit saturating counter
    // upper bit set means predict taken
    typedef enum logic [1:0] {
        cnt_strong_nt = 2'b00,
        cnt_weak_nt   = 2'b01,
        cnt_weak_t    = 2'b10,
        cnt_strong_t  = 2'b11
    } counter_t;

    // what fetch hands to decode
    // counter is the BHT value seen at fetch, written back stepped at resolution
    typedef struct packed {
        // fetch address
        word_t    pc;
        // raw instruction from imem
        word_t    instr;
        // counter and BTB both said taken
        logic     pred_taken;
        // BTB target, only meaningful with pred_taken
        word_t    pred_target;
        // BHT state read at fetch time
        counter_t counter;
    } fetch_pred_t;

endpackage

//--- logic/bht.sv
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module bht import bpred_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // fetch side lookup
    input  word_t    rd_pc_i,
    output counter_t rd_counter_o,
    // resolution side update
    input  logic     wr_en_i,
    input  word_t    wr_pc_i,
    input  logic     wr_taken_i,
    input  counter_t wr_old_counter_i
);

    counter_t                    cnt_q [`BPRED_BHT_ENTRIES];
    logic [`BPRED_BHT_IDX_W-1:0] rd_idx;
    logic [`BPRED_BHT_IDX_W-1:0] wr_idx;
    counter_t                    next_counter;

    // word aligned pc, drop the two low bits
    assign rd_idx = rd_pc_i[`BPRED_BHT_IDX_W+1:2];
    assign wr_idx = wr_pc_i[`BPRED_BHT_IDX_W+1:2];

    // combinational read, same cycle as the fetch address
    assign rd_counter_o = cnt_q[rd_idx];

    // one saturating step toward the outcome
    // works off the counter carried from fetch, no second lookup
    always_comb begin
        next_counter = wr_old_counter_i;
        unique case (wr_old_counter_i)
            cnt_strong_nt: next_counter = wr_taken_i ? cnt_weak_nt : cnt_strong_nt;
            cnt_weak_nt:   next_counter = wr_taken_i ? cnt_weak_t : cnt_strong_nt;
            cnt_weak_t:    next_counter = wr_taken_i ? cnt_strong_t : cnt_weak_nt;
            cnt_strong_t:  next_counter = wr_taken_i ? cnt_strong_t : cnt_weak_t;
            default:       next_counter = cnt_weak_nt;
        endcase
    end

    // all counters start weakly not-taken
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BPRED_BHT_ENTRIES; i++) begin
                cnt_q[i] <= cnt_weak_nt;
            end
        end else if (wr_en_i) begin
            // visible to lookups from the next cycle on
            cnt_q[wr_idx] <= next_counter;
        end
    end

endmodule

//--- logic/btb.sv
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module btb import bpred_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    // fetch side lookup
    input  word_t rd_pc_i,
    output logic  hit_o,
    output word_t target_o,
    // taken resolutions only
    input  logic  wr_en_i,
    input  word_t wr_pc_i,
    input  word_t wr_target_i
);

    logic                        valid_q  [`BPRED_BTB_ENTRIES];
    logic [`BPRED_BTB_TAG_W-1:0] tag_q    [`BPRED_BTB_ENTRIES];
    word_t                       target_q [`BPRED_BTB_ENTRIES];

    logic [`BPRED_BTB_IDX_W-1:0] rd_idx;
    logic [`BPRED_BTB_TAG_W-1:0] rd_tag;
    logic [`BPRED_BTB_IDX_W-1:0] wr_idx;
    logic [`BPRED_BTB_TAG_W-1:0] wr_tag;

    // index is pc[4:2]
    assign rd_idx = rd_pc_i[`BPRED_BTB_IDX_W+1:2];
    assign wr_idx = wr_pc_i[`BPRED_BTB_IDX_W+1:2];

    // tag is everything above the index
    assign rd_tag = rd_pc_i[`BPRED_XLEN-1:`BPRED_BTB_IDX_W+2];
    assign wr_tag = wr_pc_i[`BPRED_XLEN-1:`BPRED_BTB_IDX_W+2];

    // hit needs the entry filled and the same upper pc bits
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    // target driven regardless of hit, caller masks it
    assign target_o = target_q[rd_idx];

    // valid bits, cleared on reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BPRED_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target arrays
    // direct mapped, so a new branch simply evicts the old one at that index
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

//--- logic/fetch_pc.sv
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module fetch_pc import bpred_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    // hold the current fetch
    input  logic  stall_i,
    // mispredict from decode
    input  logic  redirect_i,
    input  word_t redirect_pc_i,
    // prediction for the current fetch
    input  logic  pred_taken_i,
    input  word_t pred_target_i,
    output word_t pc_o
);

    word_t pc_q;
    word_t pc_d;

    // next pc
    // redirect beats stall, a wrong-path fetch is never worth holding
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (stall_i) begin
            pc_d = pc_q;
        end else if (pred_taken_i) begin
            // follow the BTB target
            pc_d = pred_target_i;
        end else begin
            // sequential fetch
            pc_d = pc_q + word_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `BPRED_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // straight to the imem address, read comes back same cycle
    assign pc_o = pc_q;

endmodule

//--- logic/fetch_decode_reg.sv
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module fetch_decode_reg import bpred_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stall_i,
    // mispredict, kill whatever was fetched this cycle
    input  logic        flush_i,
    input  fetch_pred_t fetch_i,
    output logic        valid_o,
    output fetch_pred_t decode_o
);

    logic        valid_q;
    logic        pred_taken_q;
    fetch_pred_t payload_q;
    logic        load;

    // flush wins over stall
    assign load = flush_i || !stall_i;

    // control bits
    // pred_taken lives here so decode never sees a stale prediction
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q      <= 1'b0;
            pred_taken_q <= 1'b0;
        end else if (flush_i) begin
            valid_q      <= 1'b0;
            pred_taken_q <= 1'b0;
        end else if (!stall_i) begin
            // fetch always produces an instruction
            valid_q      <= 1'b1;
            pred_taken_q <= fetch_i.pred_taken;
        end
    end

    // pc, instruction, target, counter
    always_ff @(posedge clk) begin
        if (load) begin
            payload_q <= fetch_i;
        end
    end

    assign valid_o = valid_q;

    always_comb begin
        decode_o            = payload_q;
        decode_o.pred_taken = pred_taken_q;
    end

endmodule

//--- logic/mispredict_check.sv
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module mispredict_check import bpred_pkg::*; (
    // outcome from the external decoder
    input  logic  res_valid_i,
    input  logic  res_taken_i,
    input  word_t res_target_i,
    // prediction carried in the fetch-to-decode register
    input  word_t dec_pc_i,
    input  logic  pred_taken_i,
    input  word_t pred_target_i,
    output logic  mispredict_o,
    output word_t correct_pc_o,
    output logic  btb_wr_en_o
);

    logic dir_wrong;
    logic target_wrong;

    // direction disagrees
    assign dir_wrong = res_taken_i != pred_taken_i;

    // right direction, wrong place
    assign target_wrong = res_taken_i && pred_taken_i && (res_target_i != pred_target_i);

    assign mispredict_o = res_valid_i && (dir_wrong || target_wrong);

    // where fetch should have gone
    assign correct_pc_o = res_taken_i ? res_target_i : dec_pc_i + word_t'(4);

    // only taken branches earn a BTB entry
    assign btb_wr_en_o = res_valid_i && res_taken_i;

endmodule

//--- logic/fetch_frontend.sv
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module fetch_frontend import bpred_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  stall_i,
    // instruction memory, combinational read
    output word_t imem_addr_o,
    input  word_t imem_rdata_i,
    // to the decoder
    output logic  dec_valid_o,
    output word_t dec_pc_o,
    output word_t dec_instr_o,
    output logic  dec_pred_taken_o,
    output word_t dec_pred_target_o,
    // branch outcome back from the decoder
    input  logic  res_valid_i,
    input  logic  res_taken_i,
    input  word_t res_target_i
);

    word_t       pc;
    counter_t    rd_counter;
    logic        btb_hit;
    word_t       btb_target;
    logic        pred_taken;
    fetch_pred_t fetch_bundle;
    fetch_pred_t decode_bundle;
    logic        mispredict;
    word_t       correct_pc;
    logic        btb_wr_en;

    // always reading at the current pc
    assign imem_addr_o = pc;

    // taken needs both a leaning counter and a known target
    assign pred_taken = rd_counter[1] && btb_hit;

    always_comb begin
        fetch_bundle.pc          = pc;
        fetch_bundle.instr       = imem_rdata_i;
        fetch_bundle.pred_taken  = pred_taken;
        fetch_bundle.pred_target = btb_target;
        fetch_bundle.counter     = rd_counter;
    end

    assign dec_pc_o          = decode_bundle.pc;
    assign dec_instr_o       = decode_bundle.instr;
    assign dec_pred_taken_o  = decode_bundle.pred_taken;
    assign dec_pred_target_o = decode_bundle.pred_target;

    fetch_pc fetch_pc_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .redirect_i    (mispredict),
        .redirect_pc_i (correct_pc),
        .pred_taken_i  (pred_taken),
        .pred_target_i (btb_target),
        .pc_o          (pc)
    );

    // lookups on the fetch pc, updates on the decode pc
    bht bht_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .rd_pc_i          (pc),
        .rd_counter_o     (rd_counter),
        .wr_en_i          (res_valid_i),
        .wr_pc_i          (decode_bundle.pc),
        .wr_taken_i       (res_taken_i),
        .wr_old_counter_i (decode_bundle.counter)
    );

    btb btb_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rd_pc_i     (pc),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_en_i     (btb_wr_en),
        .wr_pc_i     (decode_bundle.pc),
        .wr_target_i (res_target_i)
    );

    // same mispredict flushes decode and redirects fetch
    fetch_decode_reg fetch_decode_reg_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .flush_i  (mispredict),
        .fetch_i  (fetch_bundle),
        .valid_o  (dec_valid_o),
        .decode_o (decode_bundle)
    );

    mispredict_check mispredict_check_i (
        .res_valid_i   (res_valid_i),
        .res_taken_i   (res_taken_i),
        .res_target_i  (res_target_i),
        .dec_pc_i      (decode_bundle.pc),
        .pred_taken_i  (decode_bundle.pred_taken),
        .pred_target_i (decode_bundle.pred_target),
        .mispredict_o  (mispredict),
        .correct_pc_o  (correct_pc),
        .btb_wr_en_o   (btb_wr_en)
    );

endmodule

//--- tb/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// reference tables, rebuilt from the resolutions the testbench issues
logic [1:0]                  bht_m       [`BPRED_BHT_ENTRIES];
logic                        btb_valid_m [`BPRED_BTB_ENTRIES];
logic [`BPRED_BTB_TAG_W-1:0] btb_tag_m   [`BPRED_BTB_ENTRIES];
logic [`BPRED_XLEN-1:0]      btb_tgt_m   [`BPRED_BTB_ENTRIES];

// bht index is pc[8:2]
function automatic logic [`BPRED_BHT_IDX_W-1:0] bht_index(input logic [31:0] pc);
    return pc[8:2];
endfunction

// btb index pc[4:2], tag pc[31:5]
function automatic logic [`BPRED_BTB_IDX_W-1:0] btb_index(input logic [31:0] pc);
    return pc[4:2];
endfunction

function automatic logic [`BPRED_BTB_TAG_W-1:0] btb_tag(input logic [31:0] pc);
    return pc[31:5];
endfunction

// saturating two-bit step toward the outcome
function automatic logic [1:0] counter_step(input logic [1:0] cnt, input logic taken);
    if (taken) begin
        return (cnt == 2'b11) ? cnt : cnt + 2'b01;
    end
    return (cnt == 2'b00) ? cnt : cnt - 2'b01;
endfunction

// imem content, the address with the two low bits set
function automatic logic [31:0] imem_word(input logic [31:0] addr);
    return addr | 32'h0000_0003;
endfunction

`endif

//--- tb/fetch_frontend_tb.sv
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module fetch_frontend_tb import bpred_pkg::*; ();

    `include "frontend_model.svh"

    // sum of all test lengths in cycles with resets included
    localparam int TEST_CYCLES = 540;

    logic  clk;
    logic  rst_n_i;
    logic  stall_i;
    word_t imem_addr_o;
    word_t imem_rdata_i;
    logic  dec_valid_o;
    word_t dec_pc_o;
    word_t dec_instr_o;
    logic  dec_pred_taken_o;
    word_t dec_pred_target_o;
    logic  res_valid_i;
    logic  res_taken_i;
    word_t res_target_i;

    int    errors;
    int    cycles;
    string test_name;

    // expected state of fetch and decode
    word_t      exp_pc;
    logic       exp_dec_valid;
    word_t      exp_dec_pc;
    word_t      exp_dec_instr;
    logic       exp_dec_pt;
    word_t      exp_dec_tgt;
    logic [1:0] exp_dec_cnt;

    // branch sites the decoder resolves
    int    n_sites;
    word_t site_pc  [4];
    word_t site_tgt [4];
    int    site_pct [4];

    fetch_frontend fetch_frontend_i (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .imem_addr_o       (imem_addr_o),
        .imem_rdata_i      (imem_rdata_i),
        .dec_valid_o       (dec_valid_o),
        .dec_pc_o          (dec_pc_o),
        .dec_instr_o       (dec_instr_o),
        .dec_pred_taken_o  (dec_pred_taken_o),
        .dec_pred_target_o (dec_pred_target_o),
        .res_valid_i       (res_valid_i),
        .res_taken_i       (res_taken_i),
        .res_target_i      (res_target_i)
    );

    // same-cycle instruction memory
    assign imem_rdata_i = imem_word(imem_addr_o);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // model of one clock edge
    always @(posedge clk or negedge rst_n_i) begin : model_step
        logic       mis;
        word_t      corr;
        logic [1:0] f_cnt;
        logic       f_pt;
        word_t      f_tgt;
        if (!rst_n_i) begin
            exp_pc        <= `BPRED_RESET_PC;
            exp_dec_valid <= 1'b0;
            exp_dec_pt    <= 1'b0;
            for (int i = 0; i < `BPRED_BHT_ENTRIES; i++) begin
                bht_m[i] <= 2'b01;
            end
            for (int i = 0; i < `BPRED_BTB_ENTRIES; i++) begin
                btb_valid_m[i] <= 1'b0;
            end
        end else begin
            cycles <= cycles + 1;
            // prediction for this cycle's fetch from the old tables
            f_cnt = bht_m[bht_index(exp_pc)];
            f_tgt = btb_tgt_m[btb_index(exp_pc)];
            f_pt  = f_cnt[1] && btb_valid_m[btb_index(exp_pc)]
                    && (btb_tag_m[btb_index(exp_pc)] == btb_tag(exp_pc));
            mis = res_valid_i && ((res_taken_i != exp_dec_pt)
                  || (res_taken_i && exp_dec_pt && res_target_i != exp_dec_tgt));
            corr = res_taken_i ? res_target_i : exp_dec_pc + 32'd4;
            // next fetch address
            if (mis) begin
                exp_pc <= corr;
            end else if (!stall_i) begin
                exp_pc <= f_pt ? f_tgt : exp_pc + 32'd4;
            end
            // decode register
            if (mis) begin
                exp_dec_valid <= 1'b0;
                exp_dec_pt    <= 1'b0;
            end else if (!stall_i) begin
                exp_dec_valid <= 1'b1;
                exp_dec_pc    <= exp_pc;
                exp_dec_instr <= imem_word(exp_pc);
                exp_dec_pt    <= f_pt;
                exp_dec_tgt   <= f_tgt;
                exp_dec_cnt   <= f_cnt;
            end
            // table updates from the carried counter
            if (res_valid_i) begin
                bht_m[bht_index(exp_dec_pc)] <= counter_step(exp_dec_cnt, res_taken_i);
            end
            if (res_valid_i && res_taken_i) begin
                btb_valid_m[btb_index(exp_dec_pc)] <= 1'b1;
                btb_tag_m[btb_index(exp_dec_pc)]   <= btb_tag(exp_dec_pc);
                btb_tgt_m[btb_index(exp_dec_pc)]   <= res_target_i;
            end
        end
    end

    // per-cycle checks against the model
    check_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        imem_addr_o == exp_pc)
    else begin
        errors++;
        $display("mismatch %s imem_addr_o: expected %h actual %h",
                 test_name, $sampled(exp_pc), $sampled(imem_addr_o));
    end

    check_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        dec_valid_o == exp_dec_valid)
    else begin
        errors++;
        $display("mismatch %s dec_valid_o: expected %b actual %b",
                 test_name, $sampled(exp_dec_valid), $sampled(dec_valid_o));
    end

    check_pred_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
        dec_pred_taken_o == exp_dec_pt)
    else begin
        errors++;
        $display("mismatch %s dec_pred_taken_o: expected %b actual %b",
                 test_name, $sampled(exp_dec_pt), $sampled(dec_pred_taken_o));
    end

    check_dec_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        !exp_dec_valid || dec_pc_o == exp_dec_pc)
    else begin
        errors++;
        $display("mismatch %s dec_pc_o: expected %h actual %h",
                 test_name, $sampled(exp_dec_pc), $sampled(dec_pc_o));
    end

    check_dec_instr: assert property (@(posedge clk) disable iff (!rst_n_i)
        !exp_dec_valid || dec_instr_o == exp_dec_instr)
    else begin
        errors++;
        $display("mismatch %s dec_instr_o: expected %h actual %h",
                 test_name, $sampled(exp_dec_instr), $sampled(dec_instr_o));
    end

    // target only means something on a predicted-taken fetch
    check_pred_target: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(exp_dec_valid && exp_dec_pt) || dec_pred_target_o == exp_dec_tgt)
    else begin
        errors++;
        $display("mismatch %s dec_pred_target_o: expected %h actual %h",
                 test_name, $sampled(exp_dec_tgt), $sampled(dec_pred_target_o));
    end

    task automatic apply_reset();
        @(negedge clk);
        rst_n_i      = 1'b0;
        // decoder idle while nothing sits in decode
        stall_i      = 1'b0;
        res_valid_i  = 1'b0;
        res_taken_i  = 1'b0;
        res_target_i = '0;
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;
    endtask

    task automatic set_site(input int i, input word_t pc, input word_t tgt, input int pct);
        site_pc[i]  = pc;
        site_tgt[i] = tgt;
        site_pct[i] = pct;
    endtask

    // one cycle of stimulus that resolves any site sitting in decode
    task automatic step(input logic stall);
        @(negedge clk);
        stall_i      = stall;
        res_valid_i  = 1'b0;
        res_taken_i  = 1'b0;
        res_target_i = '0;
        if (!stall && exp_dec_valid) begin
            for (int i = 0; i < n_sites; i++) begin
                if (exp_dec_pc == site_pc[i]) begin
                    res_valid_i  = 1'b1;
                    res_taken_i  = int'($urandom % 100) < site_pct[i];
                    res_target_i = site_tgt[i];
                end
            end
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'ha6f83671));
        errors       = 0;
        cycles       = 0;
        n_sites      = 0;
        rst_n_i      = 1'b0;
        stall_i      = 1'b0;
        res_valid_i  = 1'b0;
        res_taken_i  = 1'b0;
        res_target_i = '0;

        test_name = "reset_seq";
        apply_reset();
        repeat (20) step(1'b0);

        // random stall lengths with sequential fetch in between
        test_name = "stall";
        repeat (5) begin
            n = $urandom_range(8, 1);
            repeat (n) step(1'b1);
            repeat (3) step(1'b0);
        end

        // one unpredicted taken branch
        test_name = "taken_mispredict";
        apply_reset();
        set_site(0, 32'h70, 32'h200, 100);
        n_sites = 1;
        repeat (25) step(1'b0);

        // small loop that is predicted after its first pass
        test_name = "trained";
        apply_reset();
        set_site(0, 32'h90, 32'hc0, 100);
        set_site(1, 32'hc8, 32'h90, 100);
        n_sites = 2;
        repeat (60) step(1'b0);

        // mixed outcomes push counters to both ends
        test_name = "not_taken_sat";
        apply_reset();
        set_site(0, 32'h60, 32'h100, 100);
        set_site(1, 32'h108, 32'h120, 60);
        set_site(2, 32'h124, 32'h100, 50);
        set_site(3, 32'h13c, 32'h100, 100);
        n_sites = 4;
        repeat (300) step(1'b0);

        // 0x204 and 0x224 fight over btb index 1
        test_name = "btb_replace";
        apply_reset();
        set_site(0, 32'h60, 32'h200, 100);
        set_site(1, 32'h204, 32'h220, 100);
        set_site(2, 32'h224, 32'h200, 100);
        n_sites = 3;
        repeat (60) step(1'b0);

        @(negedge clk);
        $display("summary: %0d cycles checked, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // limit at twice the expected run length
    initial begin
        #(2 * TEST_CYCLES * 10);
        $display("watchdog: simulation ran past its time limit");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
+incdir+tb
logic/bpred_pkg.sv
logic/bht.sv
logic/btb.sv
logic/fetch_pc.sv
logic/fetch_decode_reg.sv
logic/mispredict_check.sv
logic/fetch_frontend.sv
tb/fetch_frontend_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module fetch_frontend_tb -f project.f \
    -o fetch_frontend_sim \
    && ./obj_dir/fetch_frontend_sim 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

[ -s sim.log ] || { echo "no simulation log"; exit 1; }

grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
